// ==== Makefile ====
TOP := zynq_shell_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --top-module $(TOP) -f all.f -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
rtl/zynq_shell_pkg.sv
rtl/shell_csr_bank.sv
rtl/host_window_xlate.sv
rtl/dram_addr_rebase.sv
rtl/mem_profiler.sv
rtl/zynq_shell_top.sv
testbench/zynq_shell_tb.sv

// ==== rtl/dram_addr_rebase.sv ====
`timescale 1ns/1ps

module dram_addr_rebase (
   input  logic                         aclk,
   input  logic                         rst_i,
   input  zynq_shell_pkg::addr_strobe_s dram_wr_i,
   input  zynq_shell_pkg::addr_strobe_s dram_rd_i,
   input  zynq_shell_pkg::addr_t        dram_base_i,
   output zynq_shell_pkg::addr_strobe_s dram_wr_o,
   output zynq_shell_pkg::addr_strobe_s dram_rd_o
);

   import zynq_shell_pkg::*;

   localparam int unsigned CH_WR = 0;
   localparam int unsigned CH_RD = 1;

   addr_strobe_s [1:0] chan_in;
   addr_strobe_s [1:0] chan_r;

   assign chan_in[CH_WR] = dram_wr_i;
   assign chan_in[CH_RD] = dram_rd_i;

   // both channels share the same rebase, the allocated base is sampled
   // in the strobe cycle
   for (genvar ch = 0; ch < 2; ch++) begin : g_chan
      addr_t ps_addr;

      // xor drops the core dram base bit, then offset into the PS buffer
      assign ps_addr = (chan_in[ch].addr ^ CORE_DRAM_BASE) + dram_base_i;

      always_ff @(posedge aclk) begin
         if (rst_i) begin
            chan_r[ch] <= '0;
         end else begin
            chan_r[ch].valid <= chan_in[ch].valid;
            chan_r[ch].addr  <= ps_addr;
         end
      end
   end

   assign dram_wr_o = chan_r[CH_WR];
   assign dram_rd_o = chan_r[CH_RD];

endmodule

// ==== rtl/host_window_xlate.sv ====
`timescale 1ns/1ps

module host_window_xlate (
   input  logic                         aclk,
   input  logic                         rst_i,
   input  zynq_shell_pkg::addr_strobe_s host_req_i,
   output zynq_shell_pkg::addr_strobe_s host_xlate_o
);

   import zynq_shell_pkg::*;

   // zero bits between the select bit and the kept offset
   localparam int unsigned GAP_W = ADDR_W - 1 - HOST_OFFSET_BITS;

   addr_t xlate_addr;
   addr_strobe_s xlate_r;

   // host 0x0xxx_xxxx lands in core dram at 0x8xxx_xxxx,
   // host 0x2xxx_xxxx lands in core local space at 0x0xxx_xxxx
   assign xlate_addr = {
      ~host_req_i.addr[HOST_SEL_BIT],
      {GAP_W{1'b0}},
      host_req_i.addr[HOST_OFFSET_BITS-1:0]
   };

   always_ff @(posedge aclk) begin
      if (rst_i) begin
         xlate_r <= '0;
      end else begin
         xlate_r.valid <= host_req_i.valid;
         xlate_r.addr  <= xlate_addr;
      end
   end

   assign host_xlate_o = xlate_r;

endmodule

// ==== rtl/mem_profiler.sv ====
`timescale 1ns/1ps

module mem_profiler #(
   parameter int unsigned PROF_REGIONS = 128
) (
   input  logic                         aclk,
   input  logic                         rst_i,
   input  logic                         core_reset_i,
   input  zynq_shell_pkg::addr_strobe_s dram_wr_i,
   input  zynq_shell_pkg::addr_strobe_s dram_rd_i,
   output zynq_shell_pkg::prof_map_t    prof_map_o
);

   import zynq_shell_pkg::*;

   prof_region_t wr_region;
   prof_region_t rd_region;
   prof_map_t    set_bits;
   prof_map_t    prof_map_r;

   // region number comes from the core address before any rebase
   assign wr_region = dram_wr_i.addr[PROF_HI_BIT:PROF_LO_BIT];
   assign rd_region = dram_rd_i.addr[PROF_HI_BIT:PROF_LO_BIT];

   // write and read may hit in the same cycle
   // regions above PROF_REGIONS are not tracked
   always_comb begin
      set_bits = '0;
      if (dram_wr_i.valid && (32'(wr_region) < PROF_REGIONS)) begin
         set_bits[wr_region] = 1'b1;
      end
      if (dram_rd_i.valid && (32'(rd_region) < PROF_REGIONS)) begin
         set_bits[rd_region] = 1'b1;
      end
   end

   // bits are sticky until the core is put back in reset
   always_ff @(posedge aclk) begin
      if (rst_i || core_reset_i) begin
         prof_map_r <= '0;
      end else begin
         prof_map_r <= prof_map_r | set_bits;
      end
   end

   assign prof_map_o = prof_map_r;

endmodule

// ==== rtl/shell_csr_bank.sv ====
`timescale 1ns/1ps

module shell_csr_bank #(
   parameter int unsigned PROF_REGIONS = 128
) (
   input  logic                     aclk,
   input  logic                     rst_i,
   input  zynq_shell_pkg::csr_write_s csr_wr_i,
   input  logic                     rd_i,
   input  zynq_shell_pkg::csr_idx_t rd_idx_i,
   input  zynq_shell_pkg::prof_map_t prof_map_i,
   output logic                     core_reset_o,
   output zynq_shell_pkg::addr_t    dram_base_o,
   output logic                     rd_valid_o,
   output zynq_shell_pkg::word_t    rd_data_o
);

   import zynq_shell_pkg::*;

   // profiler words that actually hold regions
   localparam int unsigned PROF_WORDS = PROF_REGIONS / WORD_W;

   word_t ctrl_r;
   word_t alloc_r;
   addr_t base_r;
   word_t prof_word [4];
   word_t rd_mux;

   always_ff @(posedge aclk) begin
      if (rst_i) begin
         ctrl_r  <= '0;
         alloc_r <= '0;
         base_r  <= '0;
      end else if (csr_wr_i.valid) begin
         // profiler and spare indices are read only
         case (csr_wr_i.idx)
            CSR_CTRL:  ctrl_r  <= csr_wr_i.data;
            CSR_ALLOC: alloc_r <= csr_wr_i.data;
            CSR_BASE:  base_r  <= csr_wr_i.data;
            default: ;
         endcase
      end
   end

   assign core_reset_o = ~ctrl_r[CTRL_RUN_BIT];
   assign dram_base_o  = base_r;

   // slice the bitmap, words past PROF_REGIONS read zero
   for (genvar k = 0; k < 4; k++) begin : g_prof_word
      if (k < PROF_WORDS) begin : g_live
         assign prof_word[k] = prof_map_i[k*WORD_W +: WORD_W];
      end else begin : g_none
         assign prof_word[k] = '0;
      end
   end

   always_comb begin
      case (rd_idx_i)
         CSR_CTRL:  rd_mux = ctrl_r;
         CSR_ALLOC: rd_mux = alloc_r;
         CSR_BASE:  rd_mux = base_r;
         CSR_PROF0: rd_mux = prof_word[0];
         CSR_PROF1: rd_mux = prof_word[1];
         CSR_PROF2: rd_mux = prof_word[2];
         CSR_PROF3: rd_mux = prof_word[3];
         default:   rd_mux = '0;
      endcase
   end

   // readback returns one cycle after the strobe
   always_ff @(posedge aclk) begin
      if (rst_i) begin
         rd_valid_o <= 1'b0;
         rd_data_o  <= '0;
      end else begin
         rd_valid_o <= rd_i;
         if (rd_i) begin
            rd_data_o <= rd_mux;
         end
      end
   end

endmodule

// ==== rtl/zynq_shell_pkg.sv ====
package zynq_shell_pkg;

   // widths with a meaning of their own
   localparam int unsigned ADDR_W     = 32;
   localparam int unsigned WORD_W     = 32;
   localparam int unsigned CSR_IDX_W  = 3;
   localparam int unsigned PROF_MAP_W = 128;
   localparam int unsigned PROF_REG_W = 7;

   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [CSR_IDX_W-1:0]  csr_idx_t;
   typedef logic [PROF_REG_W-1:0] prof_region_t;
   typedef logic [PROF_MAP_W-1:0] prof_map_t;

   // one-cycle address strobe, used on every address path
   typedef struct packed {
      logic  valid;
      addr_t addr;
   } addr_strobe_s;

   typedef struct packed {
      logic     valid;
      csr_idx_t idx;
      word_t    data;
   } csr_write_s;

   // register map seen by the PS
   localparam csr_idx_t CSR_CTRL  = 3'd0;
   localparam csr_idx_t CSR_ALLOC = 3'd1;
   localparam csr_idx_t CSR_BASE  = 3'd2;
   localparam csr_idx_t CSR_PROF0 = 3'd3;
   localparam csr_idx_t CSR_PROF1 = 3'd4;
   localparam csr_idx_t CSR_PROF2 = 3'd5;
   localparam csr_idx_t CSR_PROF3 = 3'd6;

   // control register, a low run bit keeps the core in reset
   localparam int unsigned CTRL_RUN_BIT = 0;

   // core dram starts here, flipped away before adding the PS base
   localparam addr_t CORE_DRAM_BASE = 32'h8000_0000;

   // host window: bit 29 picks local vs dram, low 28 bits are the offset
   localparam int unsigned HOST_SEL_BIT     = 29;
   localparam int unsigned HOST_OFFSET_BITS = 28;

   // profiler regions are 8 MB slices of the core address
   localparam int unsigned PROF_HI_BIT = 29;
   localparam int unsigned PROF_LO_BIT = 23;

endpackage

// ==== rtl/zynq_shell_top.sv ====
`timescale 1ns/1ps

module zynq_shell_top #(
   parameter int unsigned PROF_REGIONS = 128
) (
   input  logic                         aclk,
   input  logic                         rst_i,
   // PS register access
   input  zynq_shell_pkg::csr_write_s   csr_wr_i,
   input  logic                         rd_i,
   input  zynq_shell_pkg::csr_idx_t     rd_idx_i,
   // host window and core dram traffic
   input  zynq_shell_pkg::addr_strobe_s host_req_i,
   input  zynq_shell_pkg::addr_strobe_s dram_wr_i,
   input  zynq_shell_pkg::addr_strobe_s dram_rd_i,
   output logic                         core_reset_o,
   output zynq_shell_pkg::addr_strobe_s host_xlate_o,
   output zynq_shell_pkg::addr_strobe_s dram_wr_o,
   output zynq_shell_pkg::addr_strobe_s dram_rd_o,
   output logic                         rd_valid_o,
   output zynq_shell_pkg::word_t        rd_data_o
);

   import zynq_shell_pkg::*;

   logic      core_reset;
   addr_t     dram_base;
   prof_map_t prof_map;

   assign core_reset_o = core_reset;

   shell_csr_bank #(
      .PROF_REGIONS(PROF_REGIONS)
   ) u_csr_bank (
      .aclk        (aclk),
      .rst_i       (rst_i),
      .csr_wr_i    (csr_wr_i),
      .rd_i        (rd_i),
      .rd_idx_i    (rd_idx_i),
      .prof_map_i  (prof_map),
      .core_reset_o(core_reset),
      .dram_base_o (dram_base),
      .rd_valid_o  (rd_valid_o),
      .rd_data_o   (rd_data_o)
   );

   host_window_xlate u_host_xlate (
      .aclk        (aclk),
      .rst_i       (rst_i),
      .host_req_i  (host_req_i),
      .host_xlate_o(host_xlate_o)
   );

   dram_addr_rebase u_dram_rebase (
      .aclk       (aclk),
      .rst_i      (rst_i),
      .dram_wr_i  (dram_wr_i),
      .dram_rd_i  (dram_rd_i),
      .dram_base_i(dram_base),
      .dram_wr_o  (dram_wr_o),
      .dram_rd_o  (dram_rd_o)
   );

   // profiler watches core addresses, not the rebased ones
   mem_profiler #(
      .PROF_REGIONS(PROF_REGIONS)
   ) u_profiler (
      .aclk        (aclk),
      .rst_i       (rst_i),
      .core_reset_i(core_reset),
      .dram_wr_i   (dram_wr_i),
      .dram_rd_i   (dram_rd_i),
      .prof_map_o  (prof_map)
   );

endmodule

// ==== testbench/shell_trace.txt ====
# columns: op f0 f1 f2 f3 f4, all hex, unused fields are zero
# W idx data, R idx exp, L core_reset, H n a0 e0 a1 e1, D mask wa we ra re, I cycles
# out of reset the core is held and the registers read zero
L 1 0 0 0 0
R 0 00000000 0 0 0
R 1 00000000 0 0 0
R 2 00000000 0 0 0
R 7 00000000 0 0 0
# register bank
W 0 00000001 0 0 0
L 0 0 0 0 0
R 0 00000001 0 0 0
W 1 00000001 0 0 0
W 2 10000000 0 0 0
R 1 00000001 0 0 0
R 2 10000000 0 0 0
W 5 deadbeef 0 0 0
R 5 00000000 0 0 0
R 0 00000001 0 0 0
R 1 00000001 0 0 0
R 2 10000000 0 0 0
# host window translation, single and back to back
H 1 01234560 81234560 0 0
H 1 2ffffffc 0ffffffc 0 0
H 2 01234560 81234560 2ffffffc 0ffffffc
# dram rebase, write and read together, regions 0 and 31
D 3 80000040 10000040 8ffffff0 1ffffff0
R 3 80000001 0 0 0
# profiler, region 33 on write and 127 on read
D 3 90800000 20800000 bf800000 4f800000
R 4 00000002 0 0 0
R 5 00000000 0 0 0
R 6 80000000 0 0 0
I 4 0 0 0 0
R 3 80000001 0 0 0
R 4 00000002 0 0 0
R 6 80000000 0 0 0
# dropping the run bit empties the map
W 0 00000000 0 0 0
L 1 0 0 0 0
R 3 00000000 0 0 0
R 4 00000000 0 0 0
R 6 00000000 0 0 0
R 0 00000000 0 0 0

// ==== testbench/zynq_shell_tb.sv ====
`timescale 1ns/1ps

module zynq_shell_tb;

   import zynq_shell_pkg::*;

   localparam int TIMEOUT_CYCLES = 20;
   localparam int RESET_CYCLES   = 10;

   logic         aclk;
   logic         rst_i;
   csr_write_s   csr_wr_i;
   logic         rd_i;
   csr_idx_t     rd_idx_i;
   addr_strobe_s host_req_i;
   addr_strobe_s dram_wr_i;
   addr_strobe_s dram_rd_i;
   logic         core_reset_o;
   addr_strobe_s host_xlate_o;
   addr_strobe_s dram_wr_o;
   addr_strobe_s dram_rd_o;
   logic         rd_valid_o;
   word_t        rd_data_o;

   // expected responses, oldest first
   addr_t host_q [$];
   addr_t wr_q [$];
   addr_t rd_q [$];
   word_t data_q [$];

   zynq_shell_top #(
      .PROF_REGIONS(128)
   ) UUT (.*);

   always #50 aclk = ~aclk;

   task automatic end_with_failure();
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
         end_with_failure();
      end
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
         end_with_failure();
      end
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
         end_with_failure();
      end
   endtask

   task automatic report_unexpected(input string name);
      $display("%s went valid while no result was expected", name);
      end_with_failure();
   endtask

   // outputs are sampled mid cycle, away from the driving edge
   always @(negedge aclk) begin
      if (!rst_i && host_xlate_o.valid) begin
         if (host_q.size() == 0) begin
            report_unexpected("host_xlate_o");
         end else begin
            check_addr("host_xlate_o.addr", host_xlate_o.addr, host_q.pop_front());
         end
      end
      if (!rst_i && dram_wr_o.valid) begin
         if (wr_q.size() == 0) begin
            report_unexpected("dram_wr_o");
         end else begin
            check_addr("dram_wr_o.addr", dram_wr_o.addr, wr_q.pop_front());
         end
      end
      if (!rst_i && dram_rd_o.valid) begin
         if (rd_q.size() == 0) begin
            report_unexpected("dram_rd_o");
         end else begin
            check_addr("dram_rd_o.addr", dram_rd_o.addr, rd_q.pop_front());
         end
      end
      if (!rst_i && rd_valid_o) begin
         if (data_q.size() == 0) begin
            report_unexpected("rd_valid_o");
         end else begin
            check_word("rd_data_o", rd_data_o, data_q.pop_front());
         end
      end
   end

   function automatic int outstanding();
      return host_q.size() + wr_q.size() + rd_q.size() + data_q.size();
   endfunction

   task automatic wait_responses();
      int cycles;
      cycles = 0;
      while (outstanding() != 0) begin
         if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout, the DUT gave no response within %0d cycles", TIMEOUT_CYCLES);
            end_with_failure();
         end
         @(negedge aclk);
         cycles = cycles + 1;
      end
   endtask

   task automatic write_csr(input csr_idx_t idx, input word_t data);
      @(posedge aclk);
      csr_wr_i <= '{valid: 1'b1, idx: idx, data: data};
      @(posedge aclk);
      csr_wr_i.valid <= 1'b0;
   endtask

   task automatic read_csr(input csr_idx_t idx, input word_t exp);
      @(posedge aclk);
      rd_i     <= 1'b1;
      rd_idx_i <= idx;
      data_q.push_back(exp);
      @(posedge aclk);
      rd_i <= 1'b0;
      wait_responses();
   endtask

   // a count of 2 sends the second address on the very next cycle
   task automatic send_host(input int count, input addr_t a0, input addr_t e0,
                            input addr_t a1, input addr_t e1);
      @(posedge aclk);
      host_req_i <= '{valid: 1'b1, addr: a0};
      host_q.push_back(e0);
      if (count == 2) begin
         @(posedge aclk);
         host_req_i.addr <= a1;
         host_q.push_back(e1);
      end
      @(posedge aclk);
      host_req_i.valid <= 1'b0;
      wait_responses();
   endtask

   task automatic send_dram(input logic [1:0] mask, input addr_t wa, input addr_t we,
                            input addr_t ra, input addr_t re);
      @(posedge aclk);
      dram_wr_i <= '{valid: mask[0], addr: wa};
      dram_rd_i <= '{valid: mask[1], addr: ra};
      if (mask[0]) begin
         wr_q.push_back(we);
      end
      if (mask[1]) begin
         rd_q.push_back(re);
      end
      @(posedge aclk);
      dram_wr_i.valid <= 1'b0;
      dram_rd_i.valid <= 1'b0;
      wait_responses();
   endtask

   initial begin
      int fd;
      int n;
      int done;
      byte op;
      logic [31:0] f0;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      logic [31:0] f4;
      logic [8*128-1:0] skip;
      aclk       = 1'b0;
      rst_i      = 1'b1;
      csr_wr_i   = '0;
      rd_i       = 1'b0;
      rd_idx_i   = '0;
      host_req_i = '0;
      dram_wr_i  = '0;
      dram_rd_i  = '0;
      repeat (RESET_CYCLES) @(posedge aclk);
      rst_i <= 1'b0;
      fd = $fopen("testbench/shell_trace.txt", "r");
      if (fd == 0) begin
         $display("cannot open the trace file testbench/shell_trace.txt");
         end_with_failure();
      end
      done = 0;
      while (done == 0) begin
         n = $fscanf(fd, " %c", op);
         if (n != 1) begin
            done = 1;
         end else if (op == "#") begin
            n = $fgets(skip, fd);
         end else begin
            n = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
            if (n != 5) begin
               $display("trace line for op %c is missing fields", op);
               end_with_failure();
            end
            case (op)
               "W": write_csr(f0[2:0], f1);
               "R": read_csr(f0[2:0], f1);
               "H": send_host(f0, f1, f2, f3, f4);
               "D": send_dram(f0[1:0], f1, f2, f3, f4);
               "I": repeat (f0) @(posedge aclk);
               "L": begin
                  @(negedge aclk);
                  check_level("core_reset_o", core_reset_o, f0[0]);
               end
               default: begin
                  $display("unknown op %c in the trace file", op);
                  end_with_failure();
               end
            endcase
         end
      end
      $fclose(fd);
      if (outstanding() == 0) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         $display("trace ended with DUT responses still outstanding");
         end_with_failure();
      end
   end

endmodule
